//--- hw/aluCore.sv
// --------------------------------------------------
// ALU core top
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module aluCore import aluCorePkg::*; (
	input  logic        CLK,
	input  logic        arstN,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [4:0]  adr,
	input  logic [15:0] datI,
	output logic [15:0] datO,
	output logic        ack
);

	aluInstr_u   instr;
	logic        decode, execute, commit;
	logic        hostWe;
	logic [3:0]  hostAddr, rdAddr;
	logic [15:0] hostData, rdData;
	// decoder outputs
	logic        isAlu, cclLd;
	logic [3:0]  aluOp, regAAddr, regBAddr;
	logic [7:0]  imm;
	regSeq_e     regSeq;
	aluaSrc_e    aluaSrc;
	alubSrc_e    alubSrc;
	// datapath
	logic [15:0] regA, regB, result;
	flags_t      flags, flagsNew;

	wbSlaveBridge uBridge (
		.CLK, .arstN, .cyc, .stb, .we, .adr, .datI, .datO, .ack,
		.rdData, .flags, .rdAddr, .instr, .decode, .execute, .commit,
		.hostWe, .hostAddr, .hostData
	);

	aluGroupDecoder uDecoder (
		.instr, .isAlu, .aluOp, .regSeq, .regAAddr, .regBAddr,
		.aluaSrc, .alubSrc, .imm, .cclLd
	);

	aluExecute uExecute (
		.CLK, .arstN, .execute, .aluOp, .aluaSrc, .alubSrc, .imm,
		.regA, .regB, .flagsIn(flags), .result, .flagsOut(flagsNew)
	);

	resultCommit uCommit (
		.CLK, .arstN, .commit, .isAlu, .regSeq, .cclLd, .regAAddr, .regBAddr,
		.rdAddr, .result, .flagsNew, .hostWe, .hostAddr, .hostData,
		.regA, .regB, .rdData, .flags
	);

endmodule

`default_nettype wire

//--- hw/aluCorePkg.sv
// --------------------------------------------------
// ALU core types
// --------------------------------------------------
`default_nettype none

package aluCorePkg;

	// ---- instruction word ------------------------
	// 15:14 group, 13:10 op, 9:8 arg type, 7:0 args
	typedef struct packed {
		logic [1:0] group;
		logic [3:0] aluOp;
		logic [1:0] argF;
		logic [3:0] argA;
		logic [3:0] argB;
	} nibbleForm_t;

	typedef struct packed {
		logic [1:0] group;
		logic [3:0] aluOp;
		logic [1:0] argF;
		logic [7:0] imm8;   // U8 / S8 modes
	} byteForm_t;

	typedef union packed {
		nibbleForm_t nibbleForm;
		byteForm_t   byteForm;
	} aluInstr_u;

	// ---- operand sources -------------------------
	typedef enum logic {
		ALUA_REG_A = 1'b0,
		ALUA_ZERO  = 1'b1    // mov, neg, not
	} aluaSrc_e;

	typedef enum logic [1:0] {
		ALUB_REG_B = 2'd0,
		ALUB_U4    = 2'd1,
		ALUB_U8    = 2'd2,
		ALUB_S8    = 2'd3
	} alubSrc_e;

	// register sequence, rd = no writeback, ld = load A, up = update A
	typedef enum logic [2:0] {
		SEQ_NONE    = 3'd0,
		SEQ_RDA_RDB = 3'd1,
		SEQ_RDA_IMM = 3'd2,
		SEQ_LDA_RDB = 3'd3,
		SEQ_LDA_IMM = 3'd4,
		SEQ_UPA_RDB = 3'd5,
		SEQ_UPA_IMM = 3'd6
	} regSeq_e;

	// condition codes
	typedef struct packed {
		logic z;
		logic n;
		logic c;
		logic v;
	} flags_t;

endpackage

`default_nettype wire

//--- hw/aluCore_config.svh
// --------------------------------------------------
// ALU core configuration
// --------------------------------------------------
`ifndef ALUCORE_CONFIG_SVH
`define ALUCORE_CONFIG_SVH

// wishbone address map
`define ADR_INSTR       5'h00   // instruction port, write only
`define ADR_FLAGS       5'h01   // condition codes, read only
`define ADR_REG_BASE    5'h10   // 0x10..0x1f map to r0..r15

// alu operation field
`define ALU_OPX_ADD     4'h0
`define ALU_OPX_ADC     4'h1
`define ALU_OPX_SUB     4'h2
`define ALU_OPX_SBC     4'h3
`define ALU_OPX_AND     4'h4
`define ALU_OPX_OR      4'h5
`define ALU_OPX_XOR     4'h6
`define ALU_OPX_MOV     4'h7
`define ALU_OPX_CMP     4'h8
`define ALU_OPX_BIT     4'h9
`define ALU_OPX_SHL     4'hA
`define ALU_OPX_SHR     4'hB
`define ALU_OPX_ROL     4'hC
`define ALU_OPX_ROR     4'hD
`define ALU_OPX_NEG     4'hE
`define ALU_OPX_NOT     4'hF

// argument type field
`define MODE_ALU_REG_REG 2'd0   // Ra,Rb
`define MODE_ALU_REG_U4  2'd1   // Ra,U4
`define MODE_ALU_REGA_U8 2'd2   // RA,U8
`define MODE_ALU_REGA_S8 2'd3   // RA,S8

`define GROUP_ALU       2'd3

// cycles from sampled request to ack
`define INSTR_ACK_LATENCY 4
`define REG_ACK_LATENCY   1

`endif

//--- hw/aluExecute.sv
// --------------------------------------------------
// ALU execute stage
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "aluCore_config.svh"

module aluExecute import aluCorePkg::*; (
	input  logic        CLK,
	input  logic        arstN,
	input  logic        execute,
	input  logic [3:0]  aluOp,
	input  aluaSrc_e    aluaSrc,
	input  alubSrc_e    alubSrc,
	input  logic [7:0]  imm,
	input  logic [15:0] regA,
	input  logic [15:0] regB,
	input  flags_t      flagsIn,
	output logic [15:0] result,
	output flags_t      flagsOut
);

	logic [15:0] opA, opB;
	logic [16:0] sum, diff;    // bit 16 is carry / borrow
	logic [31:0] shlWide, shrWide, rolWide, rorWide;
	logic [3:0]  amt;
	logic        cin, bin;
	logic [15:0] aluRes;
	logic        cOut, vOut;

	// ---- operand selection -----------------------
	assign opA = (aluaSrc == ALUA_ZERO) ? 16'h0000 : regA;

	always_comb begin
		case (alubSrc)
			ALUB_U4: opB = {12'h000, imm[3:0]};
			ALUB_U8: opB = {8'h00, imm};
			ALUB_S8: opB = {{8{imm[7]}}, imm};   // sign extend
			default: opB = regB;
		endcase
	end

	assign cin  = (aluOp == `ALU_OPX_ADC) & flagsIn.c;
	assign bin  = (aluOp == `ALU_OPX_SBC) & flagsIn.c;
	assign sum  = {1'b0, opA} + {1'b0, opB} + {16'h0000, cin};
	assign diff = {1'b0, opA} - {1'b0, opB} - {16'h0000, bin};

	assign amt     = opB[3:0];
	assign shlWide = {16'h0000, opA} << amt;   // bit 16 is last bit out
	assign shrWide = {opA, 16'h0000} >> amt;   // bit 15 is last bit out
	assign rolWide = {opA, opA} << amt;
	assign rorWide = {opA, opA} >> amt;

	// ---- alu -------------------------------------
	always_comb begin
		aluRes = 16'h0000;
		cOut   = 1'b0;
		vOut   = 1'b0;
		case (aluOp)
			`ALU_OPX_ADD, `ALU_OPX_ADC: begin
				aluRes = sum[15:0];
				cOut   = sum[16];
				vOut   = (opA[15] == opB[15]) && (sum[15] != opA[15]);
			end
			`ALU_OPX_SUB, `ALU_OPX_SBC, `ALU_OPX_CMP, `ALU_OPX_NEG: begin
				aluRes = diff[15:0];   // neg is 0 - B
				cOut   = diff[16];
				vOut   = (opA[15] != opB[15]) && (diff[15] != opA[15]);
			end
			`ALU_OPX_AND, `ALU_OPX_BIT: aluRes = opA & opB;
			`ALU_OPX_OR:  aluRes = opA | opB;
			`ALU_OPX_XOR: aluRes = opA ^ opB;
			`ALU_OPX_MOV: aluRes = opB;
			`ALU_OPX_NOT: aluRes = ~opB;
			`ALU_OPX_SHL: begin
				aluRes = shlWide[15:0];
				cOut   = shlWide[16];   // zero when amt is 0
			end
			`ALU_OPX_SHR: begin
				aluRes = shrWide[31:16];
				cOut   = shrWide[15];
			end
			`ALU_OPX_ROL: aluRes = rolWide[31:16];
			`ALU_OPX_ROR: aluRes = rorWide[15:0];
			default:      aluRes = 16'h0000;
		endcase
	end

	// result held through commit
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			result   <= 16'h0000;
			flagsOut <= '0;
		end else if (execute) begin
			result   <= aluRes;
			flagsOut <= '{z: (aluRes == 16'h0000), n: aluRes[15], c: cOut, v: vOut};
		end
	end

endmodule

`default_nettype wire

//--- hw/aluGroupDecoder.sv
// --------------------------------------------------
// ALU group decoder
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "aluCore_config.svh"

module aluGroupDecoder import aluCorePkg::*; (
	input  aluInstr_u  instr,
	output logic       isAlu,
	output logic [3:0] aluOp,
	output regSeq_e    regSeq,
	output logic [3:0] regAAddr,
	output logic [3:0] regBAddr,
	output aluaSrc_e   aluaSrc,
	output alubSrc_e   alubSrc,
	output logic [7:0] imm,
	output logic       cclLd
);

	logic [1:0] argF;
	logic       immMode;   // any non reg-reg form

	assign isAlu    = (instr.nibbleForm.group == `GROUP_ALU);
	assign aluOp    = instr.nibbleForm.aluOp;
	assign argF     = instr.nibbleForm.argF;
	assign regBAddr = instr.nibbleForm.argB;
	assign imm      = instr.byteForm.imm8;   // U4 uses the low nibble
	assign immMode  = (argF != `MODE_ALU_REG_REG);
	assign cclLd    = (aluOp != `ALU_OPX_MOV);   // mov keeps the flags

	// ---- sequence by operation class -------------
	always_comb begin
		if (aluOp == `ALU_OPX_CMP || aluOp == `ALU_OPX_BIT)
			regSeq = immMode ? SEQ_RDA_IMM : SEQ_RDA_RDB;   // flags only
		else if (aluOp == `ALU_OPX_MOV)
			regSeq = immMode ? SEQ_LDA_IMM : SEQ_LDA_RDB;
		else
			regSeq = immMode ? SEQ_UPA_IMM : SEQ_UPA_RDB;
	end

	// unary ops see a zero A operand
	always_comb begin
		case (aluOp)
			`ALU_OPX_MOV,
			`ALU_OPX_NEG,
			`ALU_OPX_NOT: aluaSrc = ALUA_ZERO;
			default:      aluaSrc = ALUA_REG_A;
		endcase
	end

	// ---- argument type ---------------------------
	always_comb begin
		regAAddr = instr.nibbleForm.argA;
		alubSrc  = ALUB_REG_B;
		case (argF)
			`MODE_ALU_REG_REG: alubSrc = ALUB_REG_B;
			`MODE_ALU_REG_U4:  alubSrc = ALUB_U4;
			`MODE_ALU_REGA_U8: begin
				regAAddr = 4'h0;   // RA
				alubSrc  = ALUB_U8;
			end
			`MODE_ALU_REGA_S8: begin
				regAAddr = 4'h0;   // RA
				alubSrc  = ALUB_S8;
			end
			default: alubSrc = ALUB_REG_B;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/resultCommit.sv
// --------------------------------------------------
// Register file and commit
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module resultCommit import aluCorePkg::*; (
	input  logic        CLK,
	input  logic        arstN,
	input  logic        commit,
	input  logic        isAlu,
	input  regSeq_e     regSeq,
	input  logic        cclLd,
	input  logic [3:0]  regAAddr,
	input  logic [3:0]  regBAddr,
	input  logic [3:0]  rdAddr,
	input  logic [15:0] result,
	input  flags_t      flagsNew,
	input  logic        hostWe,
	input  logic [3:0]  hostAddr,
	input  logic [15:0] hostData,
	output logic [15:0] regA,
	output logic [15:0] regB,
	output logic [15:0] rdData,
	output flags_t      flags
);

	logic [15:0] regFile [16];
	logic        wbA;   // writeback to register A

	assign wbA = commit & isAlu &
		(regSeq inside {SEQ_LDA_RDB, SEQ_LDA_IMM, SEQ_UPA_RDB, SEQ_UPA_IMM});

	// ---- register file ---------------------------
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < 16; i++)
				regFile[i] <= 16'h0000;
		end else if (wbA) begin
			regFile[regAAddr] <= result;
		end else if (hostWe) begin
			regFile[hostAddr] <= hostData;   // bridge keeps this apart from commit
		end
	end

	// condition codes
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN)
			flags <= '0;
		else if (commit && isAlu && cclLd)
			flags <= flagsNew;
	end

	assign regA   = regFile[regAAddr];
	assign regB   = regFile[regBAddr];
	assign rdData = regFile[rdAddr];   // host readback

endmodule

`default_nettype wire

//--- hw/wbSlaveBridge.sv
// --------------------------------------------------
// Wishbone slave and phase sequencer
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "aluCore_config.svh"

module wbSlaveBridge import aluCorePkg::*; (
	input  logic        CLK,
	input  logic        arstN,
	// wishbone classic slave
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [4:0]  adr,
	input  logic [15:0] datI,
	output logic [15:0] datO,
	output logic        ack,
	// register file / flags readback
	input  logic [15:0] rdData,
	input  flags_t      flags,
	output logic [3:0]  rdAddr,
	// instruction and phase strobes
	output aluInstr_u   instr,
	output logic        decode,
	output logic        execute,
	output logic        commit,
	// host register write
	output logic        hostWe,
	output logic [3:0]  hostAddr,
	output logic [15:0] hostData
);

	logic busy;       // instruction in flight or ack cycle
	logic req;        // new request sampled this edge
	logic instrStart;
	logic regSel;     // address in register window

	assign busy       = decode | execute | commit | ack;
	assign req        = cyc & stb & ~busy;
	assign regSel     = ({adr[4], 4'h0} == `ADR_REG_BASE);
	assign instrStart = req & we & (adr == `ADR_INSTR);

	// host writes land on the sampling edge
	assign hostWe   = req & we & regSel;
	assign hostAddr = adr[3:0];
	assign hostData = datI;
	assign rdAddr   = adr[3:0];

	// ---- phase shift register --------------------
	// fetch at edge 1, ack at edge 4
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			decode  <= 1'b0;
			execute <= 1'b0;
			commit  <= 1'b0;
			ack     <= 1'b0;
			datO    <= 16'h0000;
		end else begin
			decode  <= instrStart;
			execute <= decode;
			commit  <= execute;
			ack     <= commit | (req & ~instrStart);   // register path acks in one cycle
			if (req && !we) begin
				if (regSel)
					datO <= rdData;
				else if (adr == `ADR_FLAGS)
					datO <= {12'h000, flags};
				else
					datO <= 16'h0000;   // unmapped or write-only
			end
		end
	end

	// instruction latch
	always_ff @(posedge CLK) begin
		if (instrStart)
			instr <= datI;
	end

endmodule

`default_nettype wire

//--- runSim.sh
#!/usr/bin/env bash
# build and run the ALU core testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module aluCoreTb \
	-Mdir obj_dir -o aluCoreSim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/aluCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
	echo "no result found in $LOG"
	exit 1
fi
exit 0

//--- verification/aluCoreModel.svh
// --------------------------------------------------
// ALU core reference model
// --------------------------------------------------
`ifndef ALUCORE_MODEL_SVH
`define ALUCORE_MODEL_SVH

logic [15:0] shadowRegs [16];   // expected register file
flags_t      shadowFlags;       // expected condition codes

// result in [15:0], flags z n c v in [19:16]
function automatic logic [19:0] modelAlu(input logic [3:0] op, input logic [15:0] a,
	input logic [15:0] b, input flags_t fIn);
	int          ua, ub, sa, sb, ur, sv, cin, amt;
	logic [15:0] r;
	logic        c, v;
	ua  = int'(a);
	ub  = int'(b);
	sa  = int'($signed(a));
	sb  = int'($signed(b));
	cin = int'(fIn.c);          // carry in, or borrow in for sbc
	amt = int'(b[3:0]);
	r   = 16'h0000;
	c   = 1'b0;
	v   = 1'b0;
	case (op)
		`ALU_OPX_ADD, `ALU_OPX_ADC: begin
			if (op == `ALU_OPX_ADD)
				cin = 0;
			ur = ua + ub + cin;
			sv = sa + sb + cin;
			r  = ur[15:0];
			c  = (ur > 65535);
			v  = (sv > 32767) || (sv < -32768);
		end
		`ALU_OPX_SUB, `ALU_OPX_SBC, `ALU_OPX_CMP: begin
			if (op != `ALU_OPX_SBC)
				cin = 0;
			ur = ua - ub - cin;
			sv = sa - sb - cin;
			r  = ur[15:0];
			c  = (ur < 0);             // borrow
			v  = (sv > 32767) || (sv < -32768);
		end
		`ALU_OPX_NEG: begin
			ur = -ub;
			r  = ur[15:0];
			c  = (ub != 0);
			v  = (-sb > 32767);         // only for 0x8000
		end
		`ALU_OPX_AND, `ALU_OPX_BIT: r = a & b;
		`ALU_OPX_OR:  r = a | b;
		`ALU_OPX_XOR: r = a ^ b;
		`ALU_OPX_MOV: r = b;
		`ALU_OPX_NOT: r = ~b;
		`ALU_OPX_SHL: begin
			r = a << amt;
			c = (amt == 0) ? 1'b0 : a[16 - amt];   // last bit out
		end
		`ALU_OPX_SHR: begin
			r = a >> amt;
			c = (amt == 0) ? 1'b0 : a[amt - 1];
		end
		`ALU_OPX_ROL: r = (a << amt) | (a >> (16 - amt));
		default:      r = (a >> amt) | (a << (16 - amt));   // ror
	endcase
	return {(r == 16'h0000), r[15], c, v, r};
endfunction

// apply one instruction word to the shadow state
task automatic modelInstr(input logic [15:0] word);
	logic [3:0]  op;
	logic [1:0]  mode;
	logic [3:0]  aIdx;
	logic [15:0] bVal;
	logic [19:0] out;
	op   = word[13:10];
	mode = word[9:8];
	if (word[15:14] == `GROUP_ALU) begin
		aIdx = mode[1] ? 4'd0 : word[7:4];   // byte modes always hit RA
		case (mode)
			`MODE_ALU_REG_REG: bVal = shadowRegs[word[3:0]];
			`MODE_ALU_REG_U4:  bVal = {12'h000, word[3:0]};
			`MODE_ALU_REGA_U8: bVal = {8'h00, word[7:0]};
			default:           bVal = {{8{word[7]}}, word[7:0]};
		endcase
		out = modelAlu(op, shadowRegs[aIdx], bVal, shadowFlags);
		if (op != `ALU_OPX_CMP && op != `ALU_OPX_BIT)
			shadowRegs[aIdx] = out[15:0];
		if (op != `ALU_OPX_MOV)
			shadowFlags = out[19:16];
	end
endtask

`endif

//--- verification/aluCoreTb.sv
// --------------------------------------------------
// ALU core testbench
// --------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "aluCore_config.svh"

module aluCoreTb import aluCorePkg::*; ();

	localparam int numRandom   = 200;
	localparam int stepOps     = 20;   // one access plus a full readback
	localparam int totalOps    = 17 + (32 + 12 + 8 + 10 + 12 + numRandom) * stepOps;
	localparam int cyclesPerOp = 20;
	localparam int watchdogNs  = totalOps * cyclesPerOp * 10 + 10000;
	localparam logic [3:0] immOps [4] = '{`ALU_OPX_ADD, `ALU_OPX_MOV, `ALU_OPX_SUB, `ALU_OPX_XOR};

	logic        CLK, arstN;
	logic        cyc, stb, we;
	logic [4:0]  adr;
	logic [15:0] datI, datO;
	logic        ack;
	int          passCount, failCount, timingFails;
	logic        pending;   // request sampled, ack outstanding
	int          waitCnt, expLat;

	`include "aluCoreModel.svh"

	aluCore UUT (.CLK, .arstN, .cyc, .stb, .we, .adr, .datI, .datO, .ack);

	initial CLK = 1'b0;
	always #5 CLK = ~CLK;   // 10 ns

	// ---- bus timing monitor ------------------------
	always @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			pending <= 1'b0;
			waitCnt <= 0;
			expLat  <= 0;
		end else if (ack) begin
			pending <= 1'b0;   // ack cycle, nothing sampled
		end else if (pending) begin
			waitCnt <= waitCnt + 1;
		end else if (cyc && stb) begin
			pending <= 1'b1;
			waitCnt <= 1;
			expLat  <= (we && adr == `ADR_INSTR) ? `INSTR_ACK_LATENCY : `REG_ACK_LATENCY;
		end
	end

	ackLatency: assert property (@(posedge CLK) disable iff (!arstN)
		ack |-> pending && waitCnt == expLat)
		else begin
			timingFails++;
			$display("** Error at %0t ns: ack not %0d cycles after the request", $time, expLat);
		end

	ackOverdue: assert property (@(posedge CLK) disable iff (!arstN)
		pending |-> waitCnt <= expLat)
		else begin
			timingFails++;
			$display("** Error at %0t ns: ack later than %0d cycles", $time, expLat);
		end

	ackPulse: assert property (@(posedge CLK) disable iff (!arstN) ack |=> !ack)
		else begin
			timingFails++;
			$display("** Error at %0t ns: ack held longer than one cycle", $time);
		end

	// ---- wishbone master ---------------------------
	task automatic waitAck();
		int n;
		n = 0;
		do begin
			@(posedge CLK);
			n++;
		end while (!ack && n < 16);
		if (!ack) begin
			failCount++;
			$display("no ack from the DUT within 16 cycles at %0t ns", $time);
		end
	endtask

	task automatic wbWrite(input logic [4:0] a, input logic [15:0] d);
		@(posedge CLK);
		cyc  <= 1'b1;
		stb  <= 1'b1;
		we   <= 1'b1;
		adr  <= a;
		datI <= d;
		waitAck();
		cyc <= 1'b0;   // drop at the ack edge
		stb <= 1'b0;
		we  <= 1'b0;
	endtask

	task automatic wbRead(input logic [4:0] a, output logic [15:0] d);
		@(posedge CLK);
		cyc <= 1'b1;
		stb <= 1'b1;
		we  <= 1'b0;
		adr <= a;
		waitAck();
		d   = datO;   // valid through the ack cycle
		cyc <= 1'b0;
		stb <= 1'b0;
	endtask

	// ---- helpers -----------------------------------
	function automatic logic [15:0] aluWord(input logic [3:0] op, input logic [1:0] mode,
		input logic [7:0] args);
		return {`GROUP_ALU, op, mode, args};
	endfunction

	task automatic hostWrite(input logic [3:0] n, input logic [15:0] d);
		wbWrite(`ADR_REG_BASE + {1'b0, n}, d);
		shadowRegs[n] = d;
	endtask

	task automatic issue(input logic [15:0] word);
		wbWrite(`ADR_INSTR, word);
		modelInstr(word);
	endtask

	task automatic checkRead(input logic [4:0] a, input logic [15:0] exp, input string what);
		logic [15:0] got;
		wbRead(a, got);
		assert (got === exp) passCount++;
		else begin
			failCount++;
			$display("** Error at %0t ns: %s read %04h, expected %04h", $time, what, got, exp);
		end
	endtask

	task automatic checkState();
		for (int i = 0; i < 16; i++)
			checkRead(`ADR_REG_BASE + 5'(i), shadowRegs[i], $sformatf("r%0d", i));
		checkRead(`ADR_FLAGS, {12'h000, shadowFlags}, "flags");
	endtask

	task automatic endTest(input string name, input int startFails);
		if (failCount + timingFails == startFails)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, failCount + timingFails - startFails);
	endtask

	// ---- tests -------------------------------------
	task automatic testReset();
		int startFails;
		startFails = failCount + timingFails;
		repeat (4) begin
			@(posedge CLK);
			assert (!ack) passCount++;
			else begin
				failCount++;
				$display("** Error at %0t ns: ack high with no request", $time);
			end
		end
		checkState();   // all zero
		endTest("reset state", startFails);
	endtask

	task automatic testRegReg();
		int         startFails;
		logic [3:0] ra, rb;
		startFails = failCount + timingFails;
		for (int k = 0; k < 32; k++) begin   // every op twice, carry in varies
			ra = 4'($urandom_range(15));
			rb = 4'($urandom_range(15));
			hostWrite(ra, 16'($urandom));
			hostWrite(rb, 16'($urandom));
			issue(aluWord(4'(k), `MODE_ALU_REG_REG, {ra, rb}));
			checkState();
		end
		endTest("register-register ops", startFails);
	endtask

	task automatic testImmediate();
		int         startFails;
		logic [3:0] ra;
		logic [7:0] imm;
		startFails = failCount + timingFails;
		for (int k = 0; k < 12; k++) begin   // u4 on any register
			ra = 4'($urandom_range(15));
			hostWrite(ra, 16'($urandom));
			issue(aluWord(4'($urandom_range(15)), `MODE_ALU_REG_U4, {ra, 4'($urandom_range(15))}));
			checkState();
		end
		for (int k = 0; k < 8; k++) begin
			imm = 8'($urandom_range(255)) | 8'h80;   // negative byte
			hostWrite(imm[7:4], 16'($urandom));      // decoy, must stay put
			hostWrite(4'd0, 16'($urandom));
			issue(aluWord(immOps[k % 4], (k < 4) ? `MODE_ALU_REGA_U8 : `MODE_ALU_REGA_S8, imm));
			checkState();
		end
		endTest("immediate modes", startFails);
	endtask

	task automatic testReadOnly();
		int startFails;
		startFails = failCount + timingFails;
		hostWrite(4'd3, 16'h1234);
		hostWrite(4'd4, 16'h1234);
		issue(aluWord(`ALU_OPX_CMP, `MODE_ALU_REG_REG, 8'h34));   // z set, r3 kept
		checkState();
		issue(aluWord(`ALU_OPX_BIT, `MODE_ALU_REG_U4, 8'h34));    // z clears again
		checkState();
		hostWrite(4'd1, 16'h0001);
		hostWrite(4'd2, 16'h0002);
		issue(aluWord(`ALU_OPX_SUB, `MODE_ALU_REG_REG, 8'h12));   // n and c set
		checkState();
		hostWrite(4'd5, 16'h5A5A);
		hostWrite(4'd6, 16'h0000);
		issue(aluWord(`ALU_OPX_MOV, `MODE_ALU_REG_REG, 8'h56));   // flags must stay
		checkState();
		issue(16'h4123);   // non-alu groups
		issue(16'h8FFF);
		issue(16'h0000);
		checkState();
		endTest("read-only and load-only ops", startFails);
	endtask

	task automatic testBusTiming();
		int startFails;
		startFails = failCount + timingFails;
		checkRead(5'h05, 16'h0000, "unmapped 0x05");
		checkRead(5'h0F, 16'h0000, "unmapped 0x0f");
		checkRead(`ADR_INSTR, 16'h0000, "instruction port");
		wbWrite(`ADR_FLAGS, 16'hFFFF);   // read only
		wbWrite(5'h07, 16'hBEEF);
		issue(aluWord(`ALU_OPX_ADD, `MODE_ALU_REG_U4, 8'h31));
		hostWrite(4'd9, 16'hA5A5);
		issue(aluWord(`ALU_OPX_ROR, `MODE_ALU_REG_REG, 8'h99));
		checkState();
		endTest("bus timing", startFails);
	endtask

	task automatic testRandom();
		int          startFails;
		int          sel;
		logic [3:0]  n;
		logic [15:0] word;
		startFails = failCount + timingFails;
		for (int k = 0; k < numRandom; k++) begin
			sel  = int'($urandom_range(7));
			n    = 4'($urandom_range(15));
			word = 16'($urandom);
			case (sel)
				0: hostWrite(n, word);
				1: checkRead(`ADR_REG_BASE + {1'b0, n}, shadowRegs[n], $sformatf("r%0d", n));
				2: issue(word);   // any group
				default: begin
					word[15:14] = `GROUP_ALU;
					issue(word);
				end
			endcase
			if (k % 10 == 9)
				checkState();
		end
		checkState();
		endTest("random sequence", startFails);
	endtask

	// ---- main --------------------------------------
	initial begin
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = 5'h00;
		datI  = 16'h0000;
		arstN = 1'b0;
		for (int i = 0; i < 16; i++)
			shadowRegs[i] = 16'h0000;
		shadowFlags = '0;
		void'($urandom(32'h25c9));
		repeat (10) @(posedge CLK);
		arstN <= 1'b1;
		testReset();
		testRegReg();
		testImmediate();
		testReadOnly();
		testBusTiming();
		testRandom();
		$display("checks: %0d passed, %0d failed", passCount, failCount + timingFails);
		if (failCount + timingFails == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// watchdog
	initial begin
		#(watchdogNs);
		$display("timeout: the tests did not finish within %0d ns", watchdogNs);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+hw
+incdir+verification
hw/aluCorePkg.sv
hw/wbSlaveBridge.sv
hw/aluGroupDecoder.sv
hw/aluExecute.sv
hw/resultCommit.sv
hw/aluCore.sv
verification/aluCoreTb.sv
